// ==== flist.f ====
verilog/mdu_pkg.sv
verilog/m_decoder.sv
verilog/mdu_multiplier.sv
verilog/mdu_divider.sv
verilog/mdu_issue_ctrl.sv
verilog/mdu_top.sv
test/mdu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the RV32M unit testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module mdu_tb \
  -f flist.f \
  -Mdir obj_dir \
  -o mdu_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/mdu_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# Pass only if the testbench printed its pass line
if echo "$output" | grep -qx "Simulation finished: PASS"; then
  exit 0
else
  exit 1
fi

// ==== test/mdu_tb.sv ====
// Testbench for mdu_top with reference model, LFSR stimulus and directed test tasks
`timescale 1ns/1ps
`default_nettype none

module mdu_tb;

  import mdu_pkg::*;

  localparam int MUL_STAGES = 2;
  // Cycles any single wait may take
  localparam int TIMEOUT = 200;
  localparam logic [31:0] MIN_INT = 32'h8000_0000;

  logic        clk;
  logic        rst_n;
  logic        issue_valid;
  logic        issue_ready;
  logic [31:0] instr;
  logic [31:0] rs1;
  logic [31:0] rs2;
  logic        result_valid;
  logic        result_ready;
  logic [31:0] result;
  logic        illegal;

  logic [31:0] lfsr_state;
  logic        hung;
  int          err_count;
  int          test_count;
  int          tests_failed;

  mdu_top #(
    .MUL_STAGES (MUL_STAGES)
  ) u_dut (
    .clk            (clk),
    .rst_n_i        (rst_n),
    .issue_valid_i  (issue_valid),
    .issue_ready_o  (issue_ready),
    .instr_i        (instr),
    .rs1_i          (rs1),
    .rs2_i          (rs2),
    .result_valid_o (result_valid),
    .result_ready_i (result_ready),
    .result_o       (result),
    .illegal_o      (illegal)
  );

  // 8 ns clock
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Ends the run once a handshake wait has run out
  initial begin
    @(posedge hung);
    $display("Simulation finished: FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Reference model and stimulus helpers
  ////////////////////////////////////////////////////////////

  // RV32M result from the ISA rules with a as rs1 and b as rs2
  function automatic logic [31:0] ref_result(input logic [2:0] funct3,
                                             input logic [31:0] a,
                                             input logic [31:0] b);
    logic [63:0]        a_sx;
    logic [63:0]        b_sx;
    logic [63:0]        a_zx;
    logic [63:0]        b_zx;
    logic [63:0]        prod;
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic               ovf;
    logic [31:0]        res;
    a_sx = {{32{a[31]}}, a};
    b_sx = {{32{b[31]}}, b};
    a_zx = {32'd0, a};
    b_zx = {32'd0, b};
    sa   = a;
    sb   = b;
    ovf  = (a == MIN_INT) && (b == 32'hFFFF_FFFF);
    res  = '0;
    // Products mod 2^64 of the extended operands
    case (funct3)
      3'd0: begin
        prod = a_zx * b_zx;
        res  = prod[31:0];
      end
      3'd1: begin
        prod = a_sx * b_sx;
        res  = prod[63:32];
      end
      3'd2: begin
        prod = a_sx * b_zx;
        res  = prod[63:32];
      end
      3'd3: begin
        prod = a_zx * b_zx;
        res  = prod[63:32];
      end
      3'd4: begin
        if (b == 32'd0) res = 32'hFFFF_FFFF;
        else if (ovf) res = a;
        else res = sa / sb;
      end
      3'd5: begin
        if (b == 32'd0) res = 32'hFFFF_FFFF;
        else res = a / b;
      end
      3'd6: begin
        if (b == 32'd0) res = a;
        else if (ovf) res = 32'd0;
        else res = sa % sb;
      end
      default: begin
        if (b == 32'd0) res = a;
        else res = a % b;
      end
    endcase
    return res;
  endfunction

  // R-type word with fixed register fields
  function automatic logic [31:0] encode_r(input logic [6:0] funct7,
                                           input logic [2:0] funct3,
                                           input logic [6:0] opcode);
    return {funct7, 5'd2, 5'd1, funct3, 5'd3, opcode};
  endfunction

  // Galois LFSR for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit
  task automatic draw_random_word(output logic [31:0] w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      w          = {w[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got == exp) else begin
      $display("Fail: %s got 0x%h expected 0x%h", name, got, exp);
      err_count++;
    end
  endtask

  // Park the calling process and let the watchdog end the run
  task automatic stop_on_timeout(input string what);
    $display("Timeout: %s", what);
    hung = 1'b1;
    forever @(negedge clk);
  endtask

  task automatic report_test(input string name, input int errs_at_start);
    test_count++;
    if (err_count != errs_at_start) tests_failed++;
    $display("Test %s done with %0d errors", name, err_count - errs_at_start);
  endtask

  ////////////////////////////////////////////////////////////
  // Handshake helpers entered and left on a falling edge
  ////////////////////////////////////////////////////////////

  // Hold word and operands until issue_ready_o takes them
  task automatic issue_instr(input logic [31:0] word, input logic [31:0] a,
                             input logic [31:0] b);
    int cycles;
    cycles      = 0;
    issue_valid = 1'b1;
    instr       = word;
    rs1         = a;
    rs2         = b;
    while (!issue_ready && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!issue_ready) begin
      stop_on_timeout("issue_ready_o never went high");
    end else begin
      // Transfer on the rising edge in between
      @(negedge clk);
      issue_valid = 1'b0;
    end
  endtask

  // Wait for the result and stall it for hold cycles before consuming it
  task automatic collect_result(input logic [31:0] exp_result, input logic exp_illegal,
                                input int exp_latency, input int hold, input string ctx);
    int          cycles;
    logic [31:0] held_result;
    logic        held_illegal;
    // Transfer edge counts as the first cycle
    cycles = 1;
    while (!result_valid && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!result_valid) begin
      stop_on_timeout({"result_valid_o never went high for ", ctx});
    end else begin
      if (exp_latency > 0) check_equal({"latency of ", ctx}, cycles, exp_latency);
      held_result  = result;
      held_illegal = illegal;
      // Back-pressure window
      for (int i = 0; i < hold; i++) begin
        @(negedge clk);
        check_equal("result_valid_o", {31'd0, result_valid}, 32'd1);
        check_equal("issue_ready_o", {31'd0, issue_ready}, 32'd0);
        check_equal("held result_o", result, held_result);
        check_equal("held illegal_o", {31'd0, illegal}, {31'd0, held_illegal});
      end
      check_equal({"result_o of ", ctx}, result, exp_result);
      check_equal({"illegal_o of ", ctx}, {31'd0, illegal}, {31'd0, exp_illegal});
      result_ready = 1'b1;
      @(negedge clk);
      result_ready = 1'b0;
      check_equal("result_valid_o after transfer", {31'd0, result_valid}, 32'd0);
      check_equal("issue_ready_o after transfer", {31'd0, issue_ready}, 32'd1);
    end
  endtask

  // Legal RV32M op against the reference model
  task automatic run_op(input logic [2:0] funct3, input logic [31:0] a,
                        input logic [31:0] b, input int hold);
    string ctx;
    int    latency;
    ctx     = $sformatf("funct3 %0d rs1 0x%h rs2 0x%h", funct3, a, b);
    // Divide latency is not fixed
    latency = funct3[2] ? 0 : MUL_STAGES + 2;
    issue_instr(encode_r(7'b000_0001, funct3, OPCODE_OP), a, b);
    collect_result(ref_result(funct3, a, b), 1'b0, latency, hold, ctx);
  endtask

  task automatic expect_illegal(input logic [31:0] word);
    issue_instr(word, 32'h1234_5678, 32'h9ABC_DEF0);
    collect_result(32'd0, 1'b1, 1, 0, $sformatf("illegal word 0x%h", word));
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic verify_reset_state();
    int start;
    start = err_count;
    check_equal("issue_ready_o", {31'd0, issue_ready}, 32'd1);
    check_equal("result_valid_o", {31'd0, result_valid}, 32'd0);
    check_equal("mul_start", {31'd0, u_dut.mul_start}, 32'd0);
    check_equal("div_start", {31'd0, u_dut.div_start}, 32'd0);
    check_equal("mul_valid", {31'd0, u_dut.mul_valid}, 32'd0);
    check_equal("div_valid", {31'd0, u_dut.div_valid}, 32'd0);
    report_test("reset", start);
  endtask

  // Corner pairs then random pairs for one funct3 group
  task automatic sweep_ops(input logic [2:0] base);
    logic [31:0] corners [5];
    logic [31:0] a;
    logic [31:0] b;
    corners = '{32'd0, 32'd1, 32'hFFFF_FFFF, MIN_INT, 32'h7FFF_FFFF};
    for (int op = 0; op < 4; op++) begin
      for (int i = 0; i < 5; i++) begin
        for (int j = 0; j < 5; j++) begin
          run_op(base + op[2:0], corners[i], corners[j], 0);
        end
      end
      for (int k = 0; k < 8; k++) begin
        draw_random_word(a);
        draw_random_word(b);
        // Small divisors give wide quotients
        if (k[0]) b = b >> 20;
        run_op(base + op[2:0], a, b, 0);
      end
    end
  endtask

  task automatic multiply_sweep();
    int start;
    start = err_count;
    sweep_ops(3'd0);
    report_test("multiplies", start);
  endtask

  task automatic divide_sweep();
    int start;
    start = err_count;
    sweep_ops(3'd4);
    report_test("divides", start);
  endtask

  task automatic illegal_words();
    int          start;
    logic [31:0] w;
    start = err_count;
    // OP-IMM opcode with the MULDIV funct7
    expect_illegal(encode_r(7'b000_0001, 3'd0, 7'h13));
    // Wrong funct7
    expect_illegal(encode_r(7'b000_0011, 3'd4, OPCODE_OP));
    expect_illegal(encode_r(7'b010_0000, 3'd1, OPCODE_OP));
    // Plain add and sltu
    expect_illegal(encode_r(7'b000_0000, 3'd0, OPCODE_OP));
    expect_illegal(encode_r(7'b000_0000, 3'd3, OPCODE_OP));
    for (int k = 0; k < 6; k++) begin
      draw_random_word(w);
      if (w[6:0] == OPCODE_OP) w[2] = ~w[2];
      expect_illegal(w);
    end
    report_test("illegal", start);
  endtask

  task automatic stall_results();
    int start;
    start = err_count;
    run_op(3'd1, 32'hDEAD_BEEF, 32'h8765_4321, 6);
    run_op(3'd6, 32'hF000_0007, 32'h0000_0013, 7);
    report_test("back_pressure", start);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rst_n        = 1'b0;
    issue_valid  = 1'b0;
    instr        = '0;
    rs1          = '0;
    rs2          = '0;
    result_ready = 1'b0;
    lfsr_state   = 32'd65795;
    hung         = 1'b0;
    err_count    = 0;
    test_count   = 0;
    tests_failed = 0;

    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    verify_reset_state();
    multiply_sweep();
    divide_sweep();
    illegal_words();
    stall_results();

    $display("Tests run %0d, tests failed %0d, failed checks %0d",
             test_count, tests_failed, err_count);
    if (err_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule : mdu_tb

`default_nettype wire

// ==== verilog/mdu_top.sv ====
// RV32M unit top level with decoder, issue controller, multiplier and divider
`timescale 1ns/1ps
`default_nettype none

module mdu_top #(
  parameter int MUL_STAGES = 2
) (
  input  wire logic        clk,
  input  wire logic        rst_n_i,
  // Issue side
  input  wire logic        issue_valid_i,
  output logic             issue_ready_o,
  input  wire logic [31:0] instr_i,
  input  wire logic [31:0] rs1_i,
  input  wire logic [31:0] rs2_i,
  // Result side
  output logic             result_valid_o,
  input  wire logic        result_ready_i,
  output logic [31:0]      result_o,
  output logic             illegal_o
);

  import mdu_pkg::*;

  decoder_ctrl_t decoder_ctrl;

  // Controller to units
  logic          mul_start;
  logic          div_start;
  logic [31:0]   op_a;
  logic [31:0]   op_b;
  logic [1:0]    mul_signed_mode;
  mul_op_e       mul_operator;
  div_op_e       div_operator;

  // Units to controller
  logic          mul_valid;
  logic [31:0]   mul_result;
  logic          div_valid;
  logic [31:0]   div_result;

  m_decoder u_decoder (
    .instr_rdata_i  (instr_i),
    .decoder_ctrl_o (decoder_ctrl)
  );

  mdu_issue_ctrl u_issue_ctrl (
    .clk               (clk),
    .rst_n_i           (rst_n_i),
    .issue_valid_i     (issue_valid_i),
    .issue_ready_o     (issue_ready_o),
    .rs1_i             (rs1_i),
    .rs2_i             (rs2_i),
    .decoder_ctrl_i    (decoder_ctrl),
    .mul_start_o       (mul_start),
    .div_start_o       (div_start),
    .op_a_o            (op_a),
    .op_b_o            (op_b),
    .mul_signed_mode_o (mul_signed_mode),
    .mul_operator_o    (mul_operator),
    .div_operator_o    (div_operator),
    .mul_valid_i       (mul_valid),
    .mul_result_i      (mul_result),
    .div_valid_i       (div_valid),
    .div_result_i      (div_result),
    .result_valid_o    (result_valid_o),
    .result_ready_i    (result_ready_i),
    .result_o          (result_o),
    .illegal_o         (illegal_o)
  );

  mdu_multiplier #(
    .MUL_STAGES (MUL_STAGES)
  ) u_multiplier (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .start_i       (mul_start),
    .op_a_i        (op_a),
    .op_b_i        (op_b),
    .signed_mode_i (mul_signed_mode),
    .operator_i    (mul_operator),
    .valid_o       (mul_valid),
    .result_o      (mul_result)
  );

  // Divisor arrives on operand a after the swap
  mdu_divider u_divider (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .start_i    (div_start),
    .divisor_i  (op_a),
    .dividend_i (op_b),
    .operator_i (div_operator),
    .valid_o    (div_valid),
    .result_o   (div_result)
  );

endmodule : mdu_top

`default_nettype wire

// ==== verilog/mdu_issue_ctrl.sv ====
// Issue/result handshake FSM, operand routing, unit dispatch and result hold
`timescale 1ns/1ps
`default_nettype none

module mdu_issue_ctrl (
  input  wire logic                   clk,
  input  wire logic                   rst_n_i,
  input  wire logic                   issue_valid_i,
  output logic                        issue_ready_o,
  input  wire logic [31:0]            rs1_i,
  input  wire logic [31:0]            rs2_i,
  input  wire mdu_pkg::decoder_ctrl_t decoder_ctrl_i,
  output logic                        mul_start_o,
  output logic                        div_start_o,
  output logic [31:0]                 op_a_o,
  output logic [31:0]                 op_b_o,
  output logic [1:0]                  mul_signed_mode_o,
  output mdu_pkg::mul_op_e            mul_operator_o,
  output mdu_pkg::div_op_e            div_operator_o,
  input  wire logic                   mul_valid_i,
  input  wire logic [31:0]            mul_result_i,
  input  wire logic                   div_valid_i,
  input  wire logic [31:0]            div_result_i,
  output logic                        result_valid_o,
  input  wire logic                   result_ready_i,
  output logic [31:0]                 result_o,
  output logic                        illegal_o
);

  import mdu_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUSY,
    ST_RESULT
  } state_e;

  state_e      state_q;
  logic        accept;
  logic [31:0] src_a;
  logic [31:0] src_b;

  // Single instruction in flight
  assign issue_ready_o  = (state_q == ST_IDLE);
  assign result_valid_o = (state_q == ST_RESULT);
  assign accept         = issue_valid_i & issue_ready_o;

  // Operand muxes swap the sources for divide
  assign src_a = (decoder_ctrl_i.alu_op_a_mux_sel == OP_A_REGB_OR_FWD) ? rs2_i : rs1_i;
  assign src_b = (decoder_ctrl_i.alu_op_b_mux_sel == OP_B_REGA_OR_FWD) ? rs1_i : rs2_i;

  ////////////////////////////////////////////////////////////
  // FSM and start pulses
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q     <= ST_IDLE;
      mul_start_o <= 1'b0;
      div_start_o <= 1'b0;
      illegal_o   <= 1'b0;
    end else begin
      // Starts last one cycle
      mul_start_o <= 1'b0;
      div_start_o <= 1'b0;
      unique case (state_q)
        ST_IDLE: begin
          if (accept) begin
            illegal_o <= decoder_ctrl_i.illegal_insn;
            if (decoder_ctrl_i.illegal_insn) begin
              // Nothing to run so answer next cycle
              state_q <= ST_RESULT;
            end else begin
              state_q     <= ST_BUSY;
              mul_start_o <= decoder_ctrl_i.mul_en;
              div_start_o <= decoder_ctrl_i.div_en;
            end
          end
        end
        ST_BUSY: begin
          if (mul_valid_i || div_valid_i) begin
            state_q <= ST_RESULT;
          end
        end
        default: begin
          // Hold until consumer takes it
          if (result_ready_i) begin
            state_q <= ST_IDLE;
          end
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Operand and result registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (accept) begin
      op_a_o            <= src_a;
      op_b_o            <= src_b;
      mul_signed_mode_o <= decoder_ctrl_i.mul_signed_mode;
      mul_operator_o    <= decoder_ctrl_i.mul_operator;
      div_operator_o    <= decoder_ctrl_i.div_operator;
    end

    // Illegal answers zero
    if (accept && decoder_ctrl_i.illegal_insn) begin
      result_o <= '0;
    end else if (state_q == ST_BUSY && mul_valid_i) begin
      result_o <= mul_result_i;
    end else if (state_q == ST_BUSY && div_valid_i) begin
      result_o <= div_result_i;
    end
  end

endmodule : mdu_issue_ctrl

`default_nettype wire

// ==== verilog/mdu_divider.sv ====
// Iterative restoring divider with RISC-V divide-by-zero and overflow results
`timescale 1ns/1ps
`default_nettype none

module mdu_divider (
  input  wire logic            clk,
  input  wire logic            rst_n_i,
  input  wire logic            start_i,
  input  wire logic [31:0]     divisor_i,
  input  wire logic [31:0]     dividend_i,
  input  wire mdu_pkg::div_op_e operator_i,
  output logic                 valid_o,
  output logic [31:0]          result_o
);

  import mdu_pkg::*;

  ////////////////////////////////////////////////////////////
  // Operand preparation
  ////////////////////////////////////////////////////////////

  logic        signed_op;
  logic        dvd_neg;
  logic        dvs_neg;
  logic [31:0] dvd_mag;
  logic [31:0] dvs_mag;

  // div and rem treat operands as two's complement
  assign signed_op = (operator_i == DIV_DIV) || (operator_i == DIV_REM);
  assign dvd_neg   = signed_op & dividend_i[31];
  assign dvs_neg   = signed_op & divisor_i[31];

  // Most negative value maps to 0x8000_0000 which is still its magnitude
  assign dvd_mag   = dvd_neg ? (32'd0 - dividend_i) : dividend_i;
  assign dvs_mag   = dvs_neg ? (32'd0 - divisor_i)  : divisor_i;

  ////////////////////////////////////////////////////////////
  // Iteration state
  ////////////////////////////////////////////////////////////

  logic        busy_q;
  logic [4:0]  cnt_q;
  logic        valid_q;

  logic [31:0] rem_q;
  logic [31:0] quo_q;
  logic [31:0] dvs_q;
  logic        quo_neg_q;
  logic        rem_neg_q;
  logic        div_zero_q;
  div_op_e     op_q;

  // One restoring step
  logic [32:0] rem_shift;
  logic [32:0] rem_diff;
  logic        rem_ge;

  // Shift next dividend bit in from the quotient register
  assign rem_shift = {rem_q, quo_q[31]};
  assign rem_ge    = (rem_shift >= {1'b0, dvs_q});
  assign rem_diff  = rem_shift - {1'b0, dvs_q};

  // Control runs 32 steps after start then pulses done for one cycle
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      busy_q  <= 1'b0;
      cnt_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      if (start_i) begin
        busy_q <= 1'b1;
        cnt_q  <= '0;
      end else if (busy_q) begin
        cnt_q <= cnt_q + 5'd1;
        if (cnt_q == 5'd31) begin
          busy_q  <= 1'b0;
          valid_q <= 1'b1;
        end
      end
    end
  end

  // Datapath
  always_ff @(posedge clk) begin
    if (start_i) begin
      rem_q      <= '0;
      quo_q      <= dvd_mag;
      dvs_q      <= dvs_mag;
      // Quotient sign from both operands and remainder sign from the dividend
      quo_neg_q  <= dvd_neg ^ dvs_neg;
      rem_neg_q  <= dvd_neg;
      div_zero_q <= (divisor_i == 32'd0);
      op_q       <= operator_i;
    end else if (busy_q) begin
      rem_q <= rem_ge ? rem_diff[31:0] : rem_shift[31:0];
      quo_q <= {quo_q[30:0], rem_ge};
    end
  end

  ////////////////////////////////////////////////////////////
  // Sign correction and result select
  ////////////////////////////////////////////////////////////

  logic [31:0] quo_fix;
  logic [31:0] rem_fix;

  // Divide by zero forces an all-ones quotient
  // Remainder already holds the dividend then
  assign quo_fix  = div_zero_q ? 32'hFFFF_FFFF :
                    (quo_neg_q ? (32'd0 - quo_q) : quo_q);
  // MIN / -1 lands on quotient MIN and remainder 0 without a special case
  assign rem_fix  = rem_neg_q ? (32'd0 - rem_q) : rem_q;

  assign valid_o  = valid_q;
  assign result_o = ((op_q == DIV_DIV) || (op_q == DIV_DIVU)) ? quo_fix : rem_fix;

endmodule : mdu_divider

`default_nettype wire

// ==== verilog/mdu_multiplier.sv ====
// Pipelined 33x33 signed multiplier with low/high product word select
`timescale 1ns/1ps
`default_nettype none

module mdu_multiplier #(
  parameter int MUL_STAGES = 2
) (
  input  wire logic            clk,
  input  wire logic            rst_n_i,
  input  wire logic            start_i,
  input  wire logic [31:0]     op_a_i,
  input  wire logic [31:0]     op_b_i,
  input  wire logic [1:0]      signed_mode_i,
  input  wire mdu_pkg::mul_op_e operator_i,
  output logic                 valid_o,
  output logic [31:0]          result_o
);

  import mdu_pkg::*;

  ////////////////////////////////////////////////////////////
  // Operand extension and product
  ////////////////////////////////////////////////////////////

  // 33-bit operands with the sign copied only in signed mode
  logic signed [32:0] op_a_ext;
  logic signed [32:0] op_b_ext;
  logic signed [65:0] product;

  assign op_a_ext = {signed_mode_i[1] & op_a_i[31], op_a_i};
  assign op_b_ext = {signed_mode_i[0] & op_b_i[31], op_b_i};

  // Full signed product covers all four sign combinations
  assign product  = op_a_ext * op_b_ext;

  ////////////////////////////////////////////////////////////
  // Pipeline stages
  ////////////////////////////////////////////////////////////

  logic [MUL_STAGES-1:0] valid_q;
  logic [65:0]           prod_q [MUL_STAGES];
  mul_op_e               op_q   [MUL_STAGES];

  // Valid chain with one bit per stage
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= start_i;
      for (int i = 1; i < MUL_STAGES; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  // Product and operator travel alongside valid
  always_ff @(posedge clk) begin
    prod_q[0] <= product;
    op_q[0]   <= operator_i;
    for (int i = 1; i < MUL_STAGES; i++) begin
      prod_q[i] <= prod_q[i-1];
      op_q[i]   <= op_q[i-1];
    end
  end

  ////////////////////////////////////////////////////////////
  // Word select
  ////////////////////////////////////////////////////////////

  assign valid_o  = valid_q[MUL_STAGES-1];

  // High word for mulh/mulhsu/mulhu and low word for mul
  assign result_o = (op_q[MUL_STAGES-1] == MUL_H) ? prod_q[MUL_STAGES-1][63:32]
                                                  : prod_q[MUL_STAGES-1][31:0];

endmodule : mdu_multiplier

`default_nettype wire

// ==== verilog/m_decoder.sv ====
// Combinational RV32M decoder, instruction word to multiply/divide control fields
`timescale 1ns/1ps
`default_nettype none

module m_decoder (
  input  wire logic [31:0]          instr_rdata_i,
  output mdu_pkg::decoder_ctrl_t    decoder_ctrl_o
);

  import mdu_pkg::*;

  // Instruction fields
  logic [6:0] opcode;
  logic [6:0] funct7;
  logic [2:0] funct3;

  assign opcode = instr_rdata_i[6:0];
  assign funct7 = instr_rdata_i[31:25];
  assign funct3 = instr_rdata_i[14:12];

  always_comb begin
    // Start from illegal, override on a match
    decoder_ctrl_o = DECODER_CTRL_ILLEGAL_INSN;

    // MULDIV group
    if (opcode == OPCODE_OP && funct7 == 7'b000_0001) begin
      decoder_ctrl_o.illegal_insn = 1'b0;
      // Both sources read, rd written
      decoder_ctrl_o.rf_we        = 1'b1;
      decoder_ctrl_o.rf_re        = 2'b11;

      unique case (funct3)
        3'b000: begin
          // mul
          decoder_ctrl_o.mul_en          = 1'b1;
          decoder_ctrl_o.mul_operator    = MUL_M32;
          decoder_ctrl_o.mul_signed_mode = 2'b00;
        end
        3'b001: begin
          // mulh
          decoder_ctrl_o.mul_en          = 1'b1;
          decoder_ctrl_o.mul_operator    = MUL_H;
          decoder_ctrl_o.mul_signed_mode = 2'b11;
        end
        3'b010: begin
          // mulhsu, rs1 signed and rs2 unsigned
          decoder_ctrl_o.mul_en          = 1'b1;
          decoder_ctrl_o.mul_operator    = MUL_H;
          decoder_ctrl_o.mul_signed_mode = 2'b10;
        end
        3'b011: begin
          // mulhu
          decoder_ctrl_o.mul_en          = 1'b1;
          decoder_ctrl_o.mul_operator    = MUL_H;
          decoder_ctrl_o.mul_signed_mode = 2'b00;
        end
        default: begin
          // div, divu, rem, remu
          // Swapped sources, divisor (rs2) on a and dividend (rs1) on b
          decoder_ctrl_o.div_en           = 1'b1;
          decoder_ctrl_o.alu_op_a_mux_sel = OP_A_REGB_OR_FWD;
          decoder_ctrl_o.alu_op_b_mux_sel = OP_B_REGA_OR_FWD;
          // Low two funct3 bits map straight onto the operator order
          unique case (funct3[1:0])
            2'b00:   decoder_ctrl_o.div_operator = DIV_DIV;
            2'b01:   decoder_ctrl_o.div_operator = DIV_DIVU;
            2'b10:   decoder_ctrl_o.div_operator = DIV_REM;
            default: decoder_ctrl_o.div_operator = DIV_REMU;
          endcase
        end
      endcase
    end
  end

endmodule : m_decoder

`default_nettype wire

// ==== verilog/mdu_pkg.sv ====
// RV32M opcode, operator and operand-select enums, decoder control struct, illegal default
`default_nettype none

package mdu_pkg;

  ////////////////////////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////////////////////////

  // Major opcode of R-type register-register ops
  localparam logic [6:0] OPCODE_OP = 7'h33;

  ////////////////////////////////////////////////////////////
  // Operators and operand selects
  ////////////////////////////////////////////////////////////

  // Multiplier result word
  typedef enum logic {
    MUL_M32 = 1'b0,  // low 32 bits of product
    MUL_H   = 1'b1   // high 32 bits of product
  } mul_op_e;

  // Divider operation
  typedef enum logic [1:0] {
    DIV_DIV  = 2'b00,
    DIV_DIVU = 2'b01,
    DIV_REM  = 2'b10,
    DIV_REMU = 2'b11
  } div_op_e;

  // Operand a source
  typedef enum logic {
    OP_A_REGA_OR_FWD = 1'b0,
    OP_A_REGB_OR_FWD = 1'b1
  } op_a_sel_e;

  // Operand b source
  typedef enum logic {
    OP_B_REGB_OR_FWD = 1'b0,
    OP_B_REGA_OR_FWD = 1'b1
  } op_b_sel_e;

  ////////////////////////////////////////////////////////////
  // Decoder control word
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic      illegal_insn;
    logic      rf_we;
    logic [1:0] rf_re;
    logic      mul_en;
    mul_op_e   mul_operator;
    // Bit 1 for operand a signed, bit 0 for operand b signed
    logic [1:0] mul_signed_mode;
    logic      div_en;
    div_op_e   div_operator;
    op_a_sel_e alu_op_a_mux_sel;
    op_b_sel_e alu_op_b_mux_sel;
  } decoder_ctrl_t;

  // Default decode, nothing enabled
  localparam decoder_ctrl_t DECODER_CTRL_ILLEGAL_INSN = '{
    illegal_insn     : 1'b1,
    rf_we            : 1'b0,
    rf_re            : 2'b00,
    mul_en           : 1'b0,
    mul_operator     : MUL_M32,
    mul_signed_mode  : 2'b00,
    div_en           : 1'b0,
    div_operator     : DIV_DIV,
    alu_op_a_mux_sel : OP_A_REGA_OR_FWD,
    alu_op_b_mux_sel : OP_B_REGB_OR_FWD
  };

endpackage : mdu_pkg

`default_nettype wire
